/* hdc_item.f */
+incdir+include
source/hdc_item_pkg.sv
source/hv_stream_if.sv
source/axil_csr.sv
source/item_generator.sv
source/hv_fifo.sv
source/stream_out.sv
source/hdc_item_top.sv
sim/tb_hdc_item.sv

/* run_sim.sh */
#!/bin/sh
# build the hdc item testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_hdc_item \
    -f hdc_item.f -o sim_hdc_item &&
./obj_dir/sim_hdc_item | tee /dev/stderr | grep -qx "test passed" &&
echo "simulation ok" || {
    echo "simulation not ok"
    exit 1
}

/* sim/tb_hdc_item.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hdc_item_config.svh"

module tb_hdc_item import hdc_item_pkg::*; ();

    // three runs of 20, 20 and 7 items
    localparam int total_items    = 47;
    localparam int timeout_cycles = 200 * total_items + 2000;
    localparam logic [31:0] count_mask = (32'd1 << `ITEM_CNT_WIDTH) - 32'd1;
    localparam logic [31:0] ctrl_addr  = 32'(`REG_CTRL_OFFSET);
    localparam logic [31:0] count_addr = 32'(`REG_COUNT_OFFSET);
    localparam logic [31:0] sent_addr  = 32'(`REG_SENT_OFFSET);

    logic           AXIS_ACLK;
    logic           S_AXI_ARESETN;
    logic [31:0]    s_axi_awaddr;
    logic           s_axi_awvalid;
    logic           s_axi_awready;
    logic [31:0]    s_axi_wdata;
    logic [3:0]     s_axi_wstrb;
    logic           s_axi_wvalid;
    logic           s_axi_wready;
    logic           s_axi_bvalid;
    logic           s_axi_bready;
    logic [31:0]    s_axi_araddr;
    logic           s_axi_arvalid;
    logic           s_axi_arready;
    logic [31:0]    s_axi_rdata;
    logic           s_axi_rvalid;
    logic           s_axi_rready;
    hv_t            m_axis_tdata;
    logic           m_axis_tvalid;
    logic           m_axis_tlast;
    logic           m_axis_tready;

    logic           random_ready;
    string          test_name;
    int             value_errors;
    int             other_errors;
    int             checks;
    int             beats;
    int             beats_before;
    hv_t            exp_data [$];
    logic           exp_last [$];
    hv_t            want_data;
    logic           want_last;

    hdc_item_top hdc_item_top_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready)
    );

    // 100 ns period
    always #50 AXIS_ACLK = ~AXIS_ACLK;

    // --------------------
    // reference model
    // --------------------
    // xorshift32 step, shifts 13 / 17 / 5
    function automatic hv_t xorshift_next(input hv_t s);
        hv_t x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // every run restarts from the seed, first item is one step on
    task automatic queue_items(input int n);
        hv_t x;
        x = `XORSHIFT_SEED;
        for (int i = 0; i < n; i++) begin
            x = xorshift_next(x);
            exp_data.push_back(x);
            exp_last.push_back(i == n - 1);
        end
    endtask

    // --------------------
    // host tasks
    // --------------------
    // called 1 ns after a rising edge, returns at the same phase
    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic aw_hit;
        logic w_hit;
        logic b_hit;
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_wstrb   = strb;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        while (s_axi_awvalid || s_axi_wvalid) begin
            // handshake seen before the edge that takes it
            @(negedge AXIS_ACLK);
            aw_hit = s_axi_awvalid && s_axi_awready;
            w_hit  = s_axi_wvalid && s_axi_wready;
            @(posedge AXIS_ACLK);
            #1;
            if (aw_hit)
                s_axi_awvalid = 1'b0;
            if (w_hit)
                s_axi_wvalid = 1'b0;
        end
        s_axi_bready = 1'b1;
        b_hit = 1'b0;
        while (!b_hit) begin
            @(negedge AXIS_ACLK);
            b_hit = s_axi_bvalid;
            @(posedge AXIS_ACLK);
            #1;
        end
        s_axi_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
        logic hit;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        hit = 1'b0;
        while (!hit) begin
            @(negedge AXIS_ACLK);
            hit = s_axi_arready;
            @(posedge AXIS_ACLK);
            #1;
        end
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        hit = 1'b0;
        while (!hit) begin
            @(negedge AXIS_ACLK);
            hit  = s_axi_rvalid;
            data = s_axi_rdata;
            @(posedge AXIS_ACLK);
            #1;
        end
        s_axi_rready = 1'b0;
    endtask

    task automatic check_word(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual == expected) else begin
            value_errors++;
            $display("error: %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic read_expect(input logic [31:0] addr, input logic [31:0] expected,
                               input string what);
        logic [31:0] word;
        axil_read(addr, word);
        check_word(what, expected, word);
    endtask

    // ends one cycle after the beat carrying tlast
    task automatic wait_run_end();
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge AXIS_ACLK);
            done = m_axis_tvalid && m_axis_tready && m_axis_tlast;
            @(posedge AXIS_ACLK);
            #1;
        end
        checks++;
        assert (exp_data.size() == 0) else begin
            other_errors++;
            $display("%s: tlast came with %0d expected items never delivered",
                     test_name, exp_data.size());
        end
    endtask

    // --------------------
    // stream checker
    // --------------------
    // negedge sample, values settled and beat taken on the next edge
    always @(negedge AXIS_ACLK) begin
        if (S_AXI_ARESETN && m_axis_tvalid && m_axis_tready) begin
            beats++;
            checks++;
            assert (exp_data.size() > 0) else begin
                other_errors++;
                $display("%s: stream beat %0d arrived with no item expected", test_name, beats);
            end
            if (exp_data.size() > 0) begin
                want_data = exp_data.pop_front();
                want_last = exp_last.pop_front();
                assert (m_axis_tdata == want_data) else begin
                    value_errors++;
                    $display("error: %s beat %0d tdata expected %h actual %h",
                             test_name, beats, want_data, m_axis_tdata);
                end
                assert (m_axis_tlast == want_last) else begin
                    value_errors++;
                    $display("error: %s beat %0d tlast expected %b actual %b",
                             test_name, beats, want_last, m_axis_tlast);
                end
            end
        end
    end

    // sink back-pressure, random about half the time when enabled
    initial begin
        void'($urandom(1));
        m_axis_tready = 1'b1;
        forever begin
            @(posedge AXIS_ACLK);
            #1;
            if (random_ready)
                m_axis_tready = (($urandom & 32'd1) == 32'd1);
            else
                m_axis_tready = 1'b1;
        end
    end

    // watchdog sized from the item total
    initial begin
        repeat (timeout_cycles) @(posedge AXIS_ACLK);
        $display("timeout: the tests did not finish within %0d clock cycles", timeout_cycles);
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors + 1);
        $display("test failed");
        $finish;
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        AXIS_ACLK     = 1'b0;
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        random_ready  = 1'b0;
        value_errors  = 0;
        other_errors  = 0;
        checks        = 0;
        beats         = 0;
        test_name     = "reset";
        repeat (16) @(posedge AXIS_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;

        // register access, masking, strobes, unmapped window
        test_name = "register access";
        read_expect(ctrl_addr, 32'd0, "ctrl after reset");
        read_expect(sent_addr, 32'd0, "sent after reset");
        axil_write(count_addr, 32'hffff_f2a5, 4'hf);
        read_expect(count_addr, 32'hffff_f2a5 & count_mask, "count masked");
        axil_write(count_addr, 32'h0000_0123, 4'h0);
        read_expect(count_addr, 32'hffff_f2a5 & count_mask, "count after zero strobe");
        axil_write(32'h0000_000c, 32'h0000_0155, 4'hf);
        axil_write(32'h0000_0404, 32'h0000_00aa, 4'hf);
        axil_write(32'h0000_0400, 32'h0000_0001, 4'hf);
        read_expect(count_addr, 32'hffff_f2a5 & count_mask, "count after unmapped writes");
        read_expect(32'h0000_000c, 32'd0, "offset 0x0c");
        read_expect(32'h0000_0404, 32'd0, "address 0x404");
        read_expect(ctrl_addr, 32'd0, "ctrl after unmapped writes");
        check_word("beats after unmapped writes", 32'd0, beats);

        test_name = "run 20 ready high";
        axil_write(count_addr, 32'd20, 4'hf);
        queue_items(20);
        axil_write(ctrl_addr, 32'd1, 4'hf);
        wait_run_end();

        test_name = "run 20 random ready";
        random_ready = 1'b1;
        queue_items(20);
        axil_write(ctrl_addr, 32'd1, 4'hf);
        wait_run_end();
        random_ready = 1'b0;

        test_name = "status and zero count";
        read_expect(ctrl_addr, 32'd0, "ctrl after run");
        read_expect(sent_addr, 32'd20, "sent after run");
        axil_write(count_addr, 32'd0, 4'hf);
        beats_before = beats;
        axil_write(ctrl_addr, 32'd1, 4'hf);
        repeat (40) @(posedge AXIS_ACLK);
        #1;
        read_expect(ctrl_addr, 32'd0, "ctrl after zero count start");
        check_word("beats after zero count start", beats_before, beats);

        test_name = "run 7 restart";
        axil_write(count_addr, 32'd7, 4'hf);
        queue_items(7);
        axil_write(ctrl_addr, 32'd1, 4'hf);
        wait_run_end();
        read_expect(sent_addr, 32'd7, "sent after short run");
        // quiet tail, any stray beat is flagged
        repeat (20) @(posedge AXIS_ACLK);

        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/hdc_item_top.sv */
`timescale 1ns/100ps
`default_nettype none

module hdc_item_top import hdc_item_pkg::*; (
    input  wire         AXIS_ACLK,
    input  wire         S_AXI_ARESETN,
    // axi-lite slave
    input  wire [31:0]  s_axi_awaddr,
    input  wire         s_axi_awvalid,
    output wire         s_axi_awready,
    input  wire [31:0]  s_axi_wdata,
    input  wire [3:0]   s_axi_wstrb,
    input  wire         s_axi_wvalid,
    output wire         s_axi_wready,
    output wire         s_axi_bvalid,
    input  wire         s_axi_bready,
    input  wire [31:0]  s_axi_araddr,
    input  wire         s_axi_arvalid,
    output wire         s_axi_arready,
    output wire [31:0]  s_axi_rdata,
    output wire         s_axi_rvalid,
    input  wire         s_axi_rready,
    // axi-stream master
    output wire hv_t    m_axis_tdata,
    output wire         m_axis_tvalid,
    output wire         m_axis_tlast,
    input  wire         m_axis_tready
);

    wire            gen_start;
    wire            run_done;
    item_cnt_t      item_count;
    item_cnt_t      sent_count;

    hv_stream_if gen_to_fifo ();
    hv_stream_if fifo_to_out ();

    // --------------------
    // control
    // --------------------
    axil_csr axil_csr_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .run_done      (run_done),
        .sent_count    (sent_count),
        .gen_start     (gen_start),
        .item_count    (item_count)
    );

    // --------------------
    // item path
    // --------------------
    item_generator item_generator_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen_start     (gen_start),
        .item_count    (item_count),
        .hv_out        (gen_to_fifo.source)
    );

    hv_fifo hv_fifo_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .hv_in         (gen_to_fifo.sink),
        .hv_out        (fifo_to_out.source)
    );

    stream_out stream_out_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen_start     (gen_start),
        .hv_in         (fifo_to_out.sink),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready),
        .run_done      (run_done),
        .sent_count    (sent_count)
    );

endmodule

`default_nettype wire

/* source/stream_out.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_out import hdc_item_pkg::*; (
    input  wire         AXIS_ACLK,
    input  wire         S_AXI_ARESETN,
    input  wire         gen_start,
    hv_stream_if.sink   hv_in,
    output hv_t         m_axis_tdata,
    output logic        m_axis_tvalid,
    output logic        m_axis_tlast,
    input  wire         m_axis_tready,
    output logic        run_done,
    output item_cnt_t   sent_count
);

    logic   beat;

    // refill when empty or the held item leaves
    assign hv_in.ready = !m_axis_tvalid || m_axis_tready;
    assign beat        = m_axis_tvalid && m_axis_tready;
    assign run_done    = beat && m_axis_tlast;

    // --------------------
    // holding register
    // --------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN)
            m_axis_tvalid <= 1'b0;
        else if (hv_in.ready)
            m_axis_tvalid <= hv_in.valid;
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (hv_in.ready && hv_in.valid) begin
            m_axis_tdata <= hv_in.data;
            m_axis_tlast <= hv_in.last;
        end
    end

    // delivered items this run
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN)
            sent_count <= '0;
        else if (gen_start)
            sent_count <= '0;
        else if (beat)
            sent_count <= sent_count + 1'b1;
    end

    a_hold_stable: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast));

endmodule

`default_nettype wire

/* source/hv_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hdc_item_config.svh"

module hv_fifo import hdc_item_pkg::*; #(
    parameter int depth = `FIFO_DEPTH
) (
    input  wire         AXIS_ACLK,
    input  wire         S_AXI_ARESETN,
    hv_stream_if.sink   hv_in,
    hv_stream_if.source hv_out
);

    localparam int ptr_w = $clog2(depth);
    localparam int fill_w = ptr_w + 1;
    localparam logic [fill_w-1:0] full_lvl = fill_w'(depth);

    hv_t                data_mem [depth];
    logic               last_mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [fill_w-1:0]  fill;
    logic               push;
    logic               pop;

    assign hv_in.ready  = (fill != full_lvl);
    assign hv_out.valid = (fill != '0);
    // head entry straight from storage
    assign hv_out.data  = data_mem[rd_ptr];
    assign hv_out.last  = last_mem[rd_ptr];

    assign push = hv_in.valid && hv_in.ready;
    assign pop  = hv_out.valid && hv_out.ready;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                fill <= fill + 1'b1;
            else if (pop && !push)
                fill <= fill - 1'b1;
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (push) begin
            data_mem[wr_ptr] <= hv_in.data;
            last_mem[wr_ptr] <= hv_in.last;
        end
    end

    // fill never passes the buffer size
    a_fill_bound: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        fill <= full_lvl);
    // pointer distance tracks the fill count
    a_ptr_gap: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        (wr_ptr - rd_ptr) == fill[ptr_w-1:0]);

endmodule

`default_nettype wire

/* source/item_generator.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hdc_item_config.svh"

module item_generator import hdc_item_pkg::*; (
    input  wire             AXIS_ACLK,
    input  wire             S_AXI_ARESETN,
    input  wire             gen_start,
    input  wire item_cnt_t  item_count,
    hv_stream_if.source     hv_out
);

    hv_t        xs_state;
    hv_t        xs_next;
    logic       busy;
    item_cnt_t  item_idx;
    logic       fire;

    // xorshift32, shifts 13 / 17 / 5
    function automatic hv_t xorshift32(input hv_t s);
        hv_t x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // first item is the successor of the seed
    assign xs_next = xorshift32(xs_state);

    assign hv_out.valid = busy;
    assign hv_out.data  = xs_next;
    // item_idx counts from 0, so item number is idx + 1
    assign hv_out.last  = (item_cnt_t'(item_idx + 1'b1) == item_count);

    assign fire = hv_out.valid && hv_out.ready;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            busy     <= 1'b0;
            item_idx <= '0;
        end else if (gen_start) begin
            busy     <= 1'b1;
            item_idx <= '0;
        end else if (fire) begin
            item_idx <= item_idx + 1'b1;
            if (hv_out.last)
                busy <= 1'b0;
        end
    end

    // prng state, stalls with back-pressure
    always_ff @(posedge AXIS_ACLK) begin
        if (gen_start)
            xs_state <= `XORSHIFT_SEED;
        else if (fire)
            xs_state <= xs_next;
    end

    // csr must not restart a run in flight
    a_no_restart: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        gen_start |-> !busy);

endmodule

`default_nettype wire

/* source/axil_csr.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hdc_item_config.svh"

module axil_csr import hdc_item_pkg::*; (
    input  wire         AXIS_ACLK,
    input  wire         S_AXI_ARESETN,
    input  wire [31:0]  s_axi_awaddr,
    input  wire         s_axi_awvalid,
    output logic        s_axi_awready,
    input  wire [31:0]  s_axi_wdata,
    input  wire [3:0]   s_axi_wstrb,
    input  wire         s_axi_wvalid,
    output logic        s_axi_wready,
    output logic        s_axi_bvalid,
    input  wire         s_axi_bready,
    input  wire [31:0]  s_axi_araddr,
    input  wire         s_axi_arvalid,
    output logic        s_axi_arready,
    output logic [31:0] s_axi_rdata,
    output logic        s_axi_rvalid,
    input  wire         s_axi_rready,
    input  wire         run_done,
    input  wire item_cnt_t sent_count,
    output logic        gen_start,
    output item_cnt_t   item_count
);

    csr_state_t                     state;
    logic [`CSR_ADDR_BITS-1:2]      wr_addr;
    logic [`CSR_ADDR_BITS-1:2]      rd_addr;
    logic [31:0]                    wr_data;
    logic [1:0]                     wr_strb;
    logic                           wr_accept;
    logic                           wr_commit;
    logic                           gen_bit;
    csr_reg_t                       wr_sel;
    csr_reg_t                       rd_sel;

    // word offsets only, anything with bits 11:10 set falls to sel_none
    function automatic csr_reg_t decode(input logic [`CSR_ADDR_BITS-1:2] addr);
        case ({addr, 2'b00})
            `REG_CTRL_OFFSET:  return sel_ctrl;
            `REG_COUNT_OFFSET: return sel_count;
            `REG_SENT_OFFSET:  return sel_sent;
            default:           return sel_none;
        endcase
    endfunction

    // --------------------
    // handshake
    // --------------------
    assign s_axi_awready = (state == st_idle) || (state == st_data_only);
    assign s_axi_wready  = (state == st_idle) || (state == st_addr_only);
    // a pending write wins over a read in idle
    assign s_axi_arready = (state == st_idle) && !s_axi_awvalid && !s_axi_wvalid;
    assign s_axi_bvalid  = (state == st_write_resp);
    assign s_axi_rvalid  = (state == st_read_resp);

    // both halves of the write are in after this edge
    assign wr_accept = ((state == st_idle) && s_axi_awvalid && s_axi_wvalid) ||
                       ((state == st_addr_only) && s_axi_wvalid) ||
                       ((state == st_data_only) && s_axi_awvalid);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state     <= st_idle;
            wr_commit <= 1'b0;
        end else begin
            // first write_resp cycle applies the write
            wr_commit <= wr_accept;
            case (state)
                st_idle: begin
                    if (wr_accept)
                        state <= st_write_resp;
                    else if (s_axi_awvalid)
                        state <= st_addr_only;
                    else if (s_axi_wvalid)
                        state <= st_data_only;
                    else if (s_axi_arvalid)
                        state <= st_read_fetch;
                end
                st_addr_only:  if (wr_accept) state <= st_write_resp;
                st_data_only:  if (wr_accept) state <= st_write_resp;
                st_write_resp: if (s_axi_bready) state <= st_idle;
                st_read_fetch: state <= st_read_resp;
                st_read_resp:  if (s_axi_rready) state <= st_idle;
                default:       state <= st_idle;
            endcase
        end
    end

    // address and data capture
    always_ff @(posedge AXIS_ACLK) begin
        if (s_axi_awvalid && s_axi_awready)
            wr_addr <= s_axi_awaddr[`CSR_ADDR_BITS-1:2];
        if (s_axi_wvalid && s_axi_wready) begin
            wr_data <= s_axi_wdata;
            wr_strb <= s_axi_wstrb[1:0];
        end
        if (s_axi_arvalid && s_axi_arready)
            rd_addr <= s_axi_araddr[`CSR_ADDR_BITS-1:2];
    end

    assign wr_sel = decode(wr_addr);
    assign rd_sel = decode(rd_addr);

    // --------------------
    // registers
    // --------------------
    // start only from idle with something to generate
    assign gen_start = wr_commit && (wr_sel == sel_ctrl) && wr_strb[0] && wr_data[0] &&
                       !gen_bit && (item_count != '0);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen_bit    <= 1'b0;
            item_count <= '0;
        end else begin
            if (run_done)
                gen_bit <= 1'b0;
            else if (gen_start)
                gen_bit <= 1'b1;
            // count frozen during a run
            if (wr_commit && (wr_sel == sel_count) && !gen_bit) begin
                if (wr_strb[0])
                    item_count[7:0] <= wr_data[7:0];
                if (wr_strb[1])
                    item_count[`ITEM_CNT_WIDTH-1:8] <= wr_data[`ITEM_CNT_WIDTH-1:8];
            end
        end
    end

    // read word, zero for unmapped
    always_ff @(posedge AXIS_ACLK) begin
        if (state == st_read_fetch) begin
            s_axi_rdata <= '0;
            case (rd_sel)
                sel_ctrl:  s_axi_rdata[0] <= gen_bit;
                sel_count: s_axi_rdata[`ITEM_CNT_WIDTH-1:0] <= item_count;
                sel_sent:  s_axi_rdata[`ITEM_CNT_WIDTH-1:0] <= sent_count;
                default:   ;
            endcase
        end
    end

    // end of run only arrives while a run is open
    a_done_in_run: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        run_done |-> gen_bit);

endmodule

`default_nettype wire

/* source/hv_stream_if.sv */
`timescale 1ns/100ps
`default_nettype none

// item handshake between generator, fifo and output stage
interface hv_stream_if import hdc_item_pkg::*; ();

    logic   valid;
    logic   ready;
    hv_t    data;
    // marks the final item of a run
    logic   last;

    // producer side
    modport source (
        output valid,
        output data,
        output last,
        input  ready
    );

    // consumer side
    modport sink (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

/* source/hdc_item_pkg.sv */
`default_nettype none

`include "hdc_item_config.svh"

package hdc_item_pkg;

    // axi-lite slave states
    typedef enum logic [2:0] {
        st_idle,
        st_addr_only,
        st_data_only,
        st_write_resp,
        st_read_fetch,
        st_read_resp
    } csr_state_t;

    // decoded register select
    typedef enum logic [1:0] {
        sel_ctrl,
        sel_count,
        sel_sent,
        sel_none
    } csr_reg_t;

    typedef logic [`HV_WIDTH-1:0]       hv_t;
    typedef logic [`ITEM_CNT_WIDTH-1:0] item_cnt_t;

endpackage

`default_nettype wire

/* include/hdc_item_config.svh */
`ifndef HDC_ITEM_CONFIG_SVH
`define HDC_ITEM_CONFIG_SVH

// --------------------
// datapath sizes
// --------------------
// one xorshift word per item at 32 dimensions
`define HV_WIDTH            32
// up to 1023 items per run
`define ITEM_CNT_WIDTH      10
`define FIFO_DEPTH          4
// restart value of the generator, must be nonzero
`define XORSHIFT_SEED       32'h2545_f491

// --------------------
// register map
// --------------------
`define CSR_ADDR_BITS       12
`define REG_CTRL_OFFSET     12'h000
`define REG_COUNT_OFFSET    12'h004
`define REG_SENT_OFFSET     12'h008

`endif
